//--- hw/barrier_table.sv
`timescale 1ns/10ps

module barrier_table
    import gpu_config_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 bar_arrive,
    input  logic [BAR_BITS-1:0]  bar_id,
    input  logic [NW_BITS:0]     bar_count,
    input  logic [NW_BITS-1:0]   bar_warp,
    output logic [NUM_WARPS-1:0] bar_stall_mask
);

    logic [NUM_WARPS-1:0] arrived [NUM_BARRIERS];
    logic [NUM_WARPS-1:0] next_set;
    logic [NW_BITS:0]     arrive_cnt;
    logic                 release_bar;

    // Waiting warps plus the one arriving now
    assign next_set = arrived[bar_id] | (NUM_WARPS'(1) << bar_warp);

    always_comb begin
        arrive_cnt = '0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            arrive_cnt = arrive_cnt + (NW_BITS + 1)'(next_set[w]);
        end
    end

    assign release_bar = arrive_cnt >= bar_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < NUM_BARRIERS; b++) begin
                arrived[b] <= '0;
            end
        end else if (bar_arrive) begin
            // Last arrival frees every waiting warp at once
            if (release_bar) begin
                arrived[bar_id] <= '0;
            end else begin
                arrived[bar_id] <= next_set;
            end
        end
    end

    // A warp held at any barrier is out of scheduling
    always_comb begin
        bar_stall_mask = '0;
        for (int b = 0; b < NUM_BARRIERS; b++) begin
            bar_stall_mask = bar_stall_mask | arrived[b];
        end
    end

endmodule

//--- hw/gpu_config_pkg.sv
package gpu_config_pkg;

    // Core geometry
    localparam int NUM_WARPS    = 4;
    localparam int NUM_THREADS  = 4;
    localparam int NW_BITS      = 2;

    // Barrier resources
    localparam int NUM_BARRIERS = 4;
    localparam int BAR_BITS     = 2;

    // Reconvergence stack, one per warp
    localparam int STACK_DEPTH  = 3;
    localparam int SP_BITS      = $clog2(STACK_DEPTH + 1);

    // Entry layout is {fall-through flag, pc, thread mask}
    localparam int STACK_W      = 1 + 32 + NUM_THREADS;

    // Reset PC of warp 0
    localparam logic [31:0] STARTUP_ADDR = 32'h8000_0000;

endpackage

//--- hw/ipdom_stack.sv
`timescale 1ns/10ps

module ipdom_stack
    import gpu_config_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               push,
    input  logic               pop,
    input  logic [STACK_W-1:0] q_fall,
    input  logic [STACK_W-1:0] q_save,
    output logic [STACK_W-1:0] top
);

    logic [STACK_W-1:0] mem [STACK_DEPTH];
    logic [SP_BITS-1:0] count;

    // A split takes two slots, so it needs room for both
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (push) begin
            if (count <= SP_BITS'(STACK_DEPTH - 2)) begin
                count <= count + SP_BITS'(2);
            end
        end else if (pop && count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Saved entry sits above the fall-through entry
    always_ff @(posedge clk) begin
        if (push && count <= SP_BITS'(STACK_DEPTH - 2)) begin
            mem[count]        <= q_fall;
            mem[count + 1'b1] <= q_save;
        end
    end

    assign top = (count == '0) ? '0 : mem[count - 1'b1];

endmodule

//--- hw/warp_ctl_pkg.sv
package warp_ctl_pkg;

    import gpu_config_pkg::*;

    // Control commands from the execute stage
    typedef enum logic [2:0] {
        OP_TMC,
        OP_WSPAWN,
        OP_SPLIT,
        OP_JOIN,
        OP_BAR,
        OP_HALT
    } ctl_op_e;

    // Split operands, also reused by TMC and WSPAWN through later_mask
    typedef struct packed {
        logic [NUM_THREADS-1:0] new_mask;
        logic [NUM_THREADS-1:0] later_mask;
    } split_view_t;

    // Barrier operands
    typedef struct packed {
        logic [2:0]          pad;
        logic [BAR_BITS-1:0] bar_id;
        logic [NW_BITS:0]    bar_count;
    } bar_view_t;

    typedef union packed {
        split_view_t split;
        bar_view_t   bar;
    } ctl_word_u;

endpackage

//--- hw/warp_ctl_top.sv
`timescale 1ns/10ps

module warp_ctl_top
    import gpu_config_pkg::*;
    import warp_ctl_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,

    input  logic                   ctl_valid,
    input  ctl_op_e                ctl_op,
    input  logic [NW_BITS-1:0]     ctl_warp,
    input  ctl_word_u              ctl_word,
    input  logic [31:0]            ctl_pc,
    input  logic                   dont_split,

    input  logic                   branch_valid,
    input  logic                   branch_taken,
    input  logic [31:0]            branch_dest,
    input  logic [NW_BITS-1:0]     branch_warp,

    input  logic                   wstall,
    input  logic [NW_BITS-1:0]     wstall_warp,

    output logic                   issue_valid,
    output logic [NW_BITS-1:0]     issue_warp,
    output logic [31:0]            issue_pc,
    output logic [NUM_THREADS-1:0] issue_mask,
    output logic                   busy
);

    logic                              bar_arrive;
    logic [BAR_BITS-1:0]               bar_id;
    logic [NW_BITS:0]                  bar_count;
    logic [NW_BITS-1:0]                bar_warp;
    logic [NUM_WARPS-1:0]              bar_stall_mask;

    logic [NUM_WARPS-1:0]              stack_push;
    logic [NUM_WARPS-1:0]              stack_pop;
    logic [STACK_W-1:0]                q_fall;
    logic [STACK_W-1:0]                q_save;
    logic [NUM_WARPS-1:0][STACK_W-1:0] stack_top;

    barrier_table barriers (
        .clk            (clk),
        .reset          (reset),
        .bar_arrive     (bar_arrive),
        .bar_id         (bar_id),
        .bar_count      (bar_count),
        .bar_warp       (bar_warp),
        .bar_stall_mask (bar_stall_mask)
    );

    // One reconvergence stack per warp, shared push operands
    for (genvar i = 0; i < NUM_WARPS; i++) begin : g_stacks
        ipdom_stack stack (
            .clk    (clk),
            .reset  (reset),
            .push   (stack_push[i]),
            .pop    (stack_pop[i]),
            .q_fall (q_fall),
            .q_save (q_save),
            .top    (stack_top[i])
        );
    end

    warp_sched sched (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .ctl_valid      (ctl_valid),
        .ctl_op         (ctl_op),
        .ctl_warp       (ctl_warp),
        .ctl_word       (ctl_word),
        .ctl_pc         (ctl_pc),
        .dont_split     (dont_split),
        .branch_valid   (branch_valid),
        .branch_taken   (branch_taken),
        .branch_dest    (branch_dest),
        .branch_warp    (branch_warp),
        .wstall         (wstall),
        .wstall_warp    (wstall_warp),
        .bar_stall_mask (bar_stall_mask),
        .stack_top      (stack_top),
        .bar_arrive     (bar_arrive),
        .bar_id         (bar_id),
        .bar_count      (bar_count),
        .bar_warp       (bar_warp),
        .stack_push     (stack_push),
        .stack_pop      (stack_pop),
        .q_fall         (q_fall),
        .q_save         (q_save),
        .issue_valid    (issue_valid),
        .issue_warp     (issue_warp),
        .issue_pc       (issue_pc),
        .issue_mask     (issue_mask),
        .busy           (busy)
    );

endmodule

//--- hw/warp_sched.sv
`timescale 1ns/10ps

module warp_sched
    import gpu_config_pkg::*;
    import warp_ctl_pkg::*;
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                stall,

    input  logic                                ctl_valid,
    input  ctl_op_e                             ctl_op,
    input  logic [NW_BITS-1:0]                  ctl_warp,
    input  ctl_word_u                           ctl_word,
    input  logic [31:0]                         ctl_pc,
    input  logic                                dont_split,

    input  logic                                branch_valid,
    input  logic                                branch_taken,
    input  logic [31:0]                         branch_dest,
    input  logic [NW_BITS-1:0]                  branch_warp,

    input  logic                                wstall,
    input  logic [NW_BITS-1:0]                  wstall_warp,

    input  logic [NUM_WARPS-1:0]                bar_stall_mask,
    input  logic [NUM_WARPS-1:0][STACK_W-1:0]   stack_top,

    output logic                                bar_arrive,
    output logic [BAR_BITS-1:0]                 bar_id,
    output logic [NW_BITS:0]                    bar_count,
    output logic [NW_BITS-1:0]                  bar_warp,
    output logic [NUM_WARPS-1:0]                stack_push,
    output logic [NUM_WARPS-1:0]                stack_pop,
    output logic [STACK_W-1:0]                  q_fall,
    output logic [STACK_W-1:0]                  q_save,

    output logic                                issue_valid,
    output logic [NW_BITS-1:0]                  issue_warp,
    output logic [31:0]                         issue_pc,
    output logic [NUM_THREADS-1:0]              issue_mask,
    output logic                                busy
);

    logic [NUM_WARPS-1:0]   active;
    logic [NUM_WARPS-1:0]   stalled;
    logic [NUM_WARPS-1:0]   visible;
    logic [NUM_WARPS-1:0]   no_split;
    logic [31:0]            pc   [NUM_WARPS];
    logic [NUM_THREADS-1:0] mask [NUM_WARPS];

    logic [NUM_WARPS-1:0]   eligible;
    logic [NUM_WARPS-1:0]   vis_elig;
    logic [NUM_WARPS-1:0]   cand;
    logic [NW_BITS-1:0]     chosen;
    logic                   found;
    logic                   blocked;
    logic                   advance;
    logic                   refill;

    logic                   join_fall;
    logic [31:0]            join_pc;
    logic [NUM_THREADS-1:0] join_mask;

    // Warps with an empty mask have nothing to run
    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            eligible[w] = active[w] && !stalled[w] && !bar_stall_mask[w] && (mask[w] != '0);
        end
    end

    assign vis_elig = visible & eligible;
    assign cand     = (vis_elig != '0) ? vis_elig : eligible;

    // Lowest index wins
    always_comb begin
        chosen = '0;
        for (int w = NUM_WARPS - 1; w >= 0; w--) begin
            if (cand[w]) begin
                chosen = NW_BITS'(w);
            end
        end
    end

    assign found = cand != '0;

    // Same-cycle updates to the chosen warp hold issue back
    assign blocked = (ctl_valid && (ctl_op == OP_JOIN || ctl_warp == chosen))
                   || (branch_valid && branch_warp == chosen)
                   || (wstall && wstall_warp == chosen);

    assign issue_valid = found && !blocked && !reset;
    assign issue_warp  = chosen;
    assign issue_pc    = pc[chosen];
    assign issue_mask  = mask[chosen];
    assign busy        = active != '0;

    assign advance = issue_valid && !stall;
    assign refill  = (vis_elig == '0) && !blocked && !stall;

    // Barrier request straight from the command
    assign bar_arrive = ctl_valid && ctl_op == OP_BAR;
    assign bar_id     = ctl_word.bar.bar_id;
    assign bar_count  = ctl_word.bar.bar_count;
    assign bar_warp   = ctl_warp;

    assign q_fall = {1'b1, 32'b0, mask[ctl_warp]};
    assign q_save = {1'b0, ctl_pc, ctl_word.split.later_mask};

    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            stack_push[w] = ctl_valid && ctl_op == OP_SPLIT && !dont_split
                         && ctl_warp == NW_BITS'(w);
            stack_pop[w]  = ctl_valid && ctl_op == OP_JOIN && !no_split[w]
                         && ctl_warp == NW_BITS'(w);
        end
    end

    assign {join_fall, join_pc, join_mask} = stack_top[ctl_warp];

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= NUM_WARPS'(1);
            visible  <= NUM_WARPS'(1);
            stalled  <= '0;
            no_split <= '0;
            for (int w = 0; w < NUM_WARPS; w++) begin
                pc[w]   <= STARTUP_ADDR;
                mask[w] <= NUM_THREADS'(1);
            end
        end else begin
            if (refill) begin
                visible <= eligible;
            end

            if (advance) begin
                visible[chosen] <= 1'b0;
                pc[chosen]      <= pc[chosen] + 32'd4;
            end

            if (ctl_valid) begin
                case (ctl_op)
                    OP_TMC: begin
                        mask[ctl_warp]    <= ctl_word.split.later_mask;
                        stalled[ctl_warp] <= 1'b0;
                    end
                    OP_WSPAWN: begin
                        // Only idle warps are started
                        for (int w = 0; w < NUM_WARPS; w++) begin
                            if (ctl_word.split.later_mask[w] && !active[w]) begin
                                active[w]  <= 1'b1;
                                stalled[w] <= 1'b0;
                                pc[w]      <= ctl_pc;
                                mask[w]    <= NUM_THREADS'(1);
                            end
                        end
                    end
                    OP_SPLIT: begin
                        stalled[ctl_warp]  <= 1'b0;
                        no_split[ctl_warp] <= dont_split;
                        if (!dont_split) begin
                            mask[ctl_warp] <= ctl_word.split.new_mask;
                        end
                    end
                    OP_JOIN: begin
                        no_split[ctl_warp] <= 1'b0;
                        if (!no_split[ctl_warp]) begin
                            mask[ctl_warp] <= join_mask;
                            if (!join_fall) begin
                                pc[ctl_warp] <= join_pc;
                            end
                        end
                    end
                    OP_BAR: begin
                        // Arrival ends the decode stall, barrier holds it now
                        stalled[ctl_warp] <= 1'b0;
                    end
                    OP_HALT: begin
                        active[ctl_warp]  <= 1'b0;
                        visible[ctl_warp] <= 1'b0;
                    end
                    default: begin
                    end
                endcase
            end

            if (wstall) begin
                stalled[wstall_warp] <= 1'b1;
                visible[wstall_warp] <= 1'b0;
            end

            // Branch resolution wins over a same-cycle wstall
            if (branch_valid) begin
                stalled[branch_warp] <= 1'b0;
                if (branch_taken) begin
                    pc[branch_warp] <= branch_dest;
                end
            end
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the warp control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f vlog.f \
    --top-module warp_ctl_tb \
    -Mdir obj_dir

# A failed assertion stops the model before the pass line is printed
sim_out=$(./obj_dir/Vwarp_ctl_tb) || true
echo "$sim_out"

if grep -qxF "PASS: all tests" <<< "$sim_out"; then
    exit 0
fi
exit 1

//--- sim/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for the first 10 rising edges
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- sim/warp_ctl_checker.sv
`timescale 1ns/10ps

module warp_ctl_checker
    import gpu_config_pkg::*;
    import warp_ctl_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   ctl_valid,
    input  ctl_op_e                ctl_op,
    input  logic [NW_BITS-1:0]     ctl_warp,
    input  ctl_word_u              ctl_word,
    input  logic [31:0]            ctl_pc,
    input  logic                   dont_split,
    input  logic                   branch_valid,
    input  logic                   branch_taken,
    input  logic [31:0]            branch_dest,
    input  logic [NW_BITS-1:0]     branch_warp,
    input  logic                   wstall,
    input  logic [NW_BITS-1:0]     wstall_warp,
    input  logic                   issue_valid,
    input  logic [NW_BITS-1:0]     issue_warp,
    input  logic [31:0]            issue_pc,
    input  logic [NUM_THREADS-1:0] issue_mask,
    input  logic                   busy,
    output int                     checks,
    output int                     errors
);

    // Model of the warp state
    logic [NUM_WARPS-1:0]   active;
    logic [NUM_WARPS-1:0]   stalled;
    logic [NUM_WARPS-1:0]   visible;
    logic [NUM_WARPS-1:0]   skip_join;
    logic [31:0]            pc      [NUM_WARPS];
    logic [NUM_THREADS-1:0] mask    [NUM_WARPS];
    logic [NUM_WARPS-1:0]   waiting [NUM_BARRIERS];

    // Reconvergence stacks, entry zero at the bottom
    logic                   s_fall  [NUM_WARPS][STACK_DEPTH];
    logic [31:0]            s_pc    [NUM_WARPS][STACK_DEPTH];
    logic [NUM_THREADS-1:0] s_mask  [NUM_WARPS][STACK_DEPTH];
    int                     depth   [NUM_WARPS];

    initial begin
        checks = 0;
        errors = 0;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic clear_model();
        active    = NUM_WARPS'(1);
        visible   = NUM_WARPS'(1);
        stalled   = '0;
        skip_join = '0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            pc[w]    = STARTUP_ADDR;
            mask[w]  = NUM_THREADS'(1);
            depth[w] = 0;
        end
        for (int b = 0; b < NUM_BARRIERS; b++) begin
            waiting[b] = '0;
        end
    endtask

    task automatic step_model();
        logic [NUM_WARPS-1:0]   held;
        logic [NUM_WARPS-1:0]   ready;
        logic [NUM_WARPS-1:0]   in_round;
        logic [NUM_WARPS-1:0]   pool;
        logic [NUM_WARPS-1:0]   next_set;
        logic [NW_BITS-1:0]     pick;
        logic                   hold;
        logic                   exp_valid;
        logic                   t_fall;
        logic [31:0]            t_pc;
        logic [NUM_THREADS-1:0] t_mask;
        int                     d;

        held = '0;
        for (int b = 0; b < NUM_BARRIERS; b++) begin
            held = held | waiting[b];
        end
        for (int w = 0; w < NUM_WARPS; w++) begin
            ready[w] = active[w] && !stalled[w] && !held[w] && mask[w] != '0;
        end
        in_round = visible & ready;
        pool     = (in_round != '0) ? in_round : ready;
        pick     = '0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (pool[w]) begin
                pick = NW_BITS'(w);
                break;
            end
        end
        hold = (ctl_valid && (ctl_op == OP_JOIN || ctl_warp == pick))
            || (branch_valid && branch_warp == pick)
            || (wstall && wstall_warp == pick);
        exp_valid = (pool != '0) && !hold;

        compare("issue_valid", 32'(issue_valid), 32'(exp_valid));
        if (exp_valid) begin
            compare("issue_warp", 32'(issue_warp), 32'(pick));
            compare("issue_pc", issue_pc, pc[pick]);
            compare("issue_mask", 32'(issue_mask), 32'(mask[pick]));
        end
        compare("busy", 32'(busy), 32'(active != '0));

        // Next state, in the order later updates take priority
        if (in_round == '0 && !hold && !stall) begin
            visible = ready;
        end
        if (exp_valid && !stall) begin
            visible[pick] = 1'b0;
            pc[pick]      = pc[pick] + 32'd4;
        end

        if (ctl_valid) begin
            d = depth[ctl_warp];
            case (ctl_op)
                OP_TMC: begin
                    mask[ctl_warp]    = ctl_word.split.later_mask;
                    stalled[ctl_warp] = 1'b0;
                end
                OP_WSPAWN: begin
                    for (int w = 0; w < NUM_WARPS; w++) begin
                        if (ctl_word.split.later_mask[w] && !active[w]) begin
                            active[w]  = 1'b1;
                            stalled[w] = 1'b0;
                            pc[w]      = ctl_pc;
                            mask[w]    = NUM_THREADS'(1);
                        end
                    end
                end
                OP_SPLIT: begin
                    stalled[ctl_warp]   = 1'b0;
                    skip_join[ctl_warp] = dont_split;
                    if (!dont_split) begin
                        if (d + 2 <= STACK_DEPTH) begin
                            s_fall[ctl_warp][d]     = 1'b1;
                            s_pc[ctl_warp][d]       = '0;
                            s_mask[ctl_warp][d]     = mask[ctl_warp];
                            s_fall[ctl_warp][d + 1] = 1'b0;
                            s_pc[ctl_warp][d + 1]   = ctl_pc;
                            s_mask[ctl_warp][d + 1] = ctl_word.split.later_mask;
                            depth[ctl_warp]         = d + 2;
                        end
                        mask[ctl_warp] = ctl_word.split.new_mask;
                    end
                end
                OP_JOIN: begin
                    if (!skip_join[ctl_warp]) begin
                        // Empty stack reads back as an all-zero entry
                        t_fall = 1'b0;
                        t_pc   = '0;
                        t_mask = '0;
                        if (d > 0) begin
                            t_fall          = s_fall[ctl_warp][d - 1];
                            t_pc            = s_pc[ctl_warp][d - 1];
                            t_mask          = s_mask[ctl_warp][d - 1];
                            depth[ctl_warp] = d - 1;
                        end
                        mask[ctl_warp] = t_mask;
                        if (!t_fall) begin
                            pc[ctl_warp] = t_pc;
                        end
                    end
                    skip_join[ctl_warp] = 1'b0;
                end
                OP_BAR: begin
                    stalled[ctl_warp] = 1'b0;
                    next_set = waiting[ctl_word.bar.bar_id] | (NUM_WARPS'(1) << ctl_warp);
                    if ($countones(next_set) >= int'(ctl_word.bar.bar_count)) begin
                        waiting[ctl_word.bar.bar_id] = '0;
                    end else begin
                        waiting[ctl_word.bar.bar_id] = next_set;
                    end
                end
                OP_HALT: begin
                    active[ctl_warp]  = 1'b0;
                    visible[ctl_warp] = 1'b0;
                end
                default: begin
                end
            endcase
        end

        if (wstall) begin
            stalled[wstall_warp] = 1'b1;
            visible[wstall_warp] = 1'b0;
        end
        if (branch_valid) begin
            stalled[branch_warp] = 1'b0;
            if (branch_taken) begin
                pc[branch_warp] = branch_dest;
            end
        end
    endtask

    // Inputs change on the rising edge, so the falling edge sees settled values
    always @(negedge clk) begin
        if (reset) begin
            clear_model();
            compare("issue_valid", 32'(issue_valid), 32'd0);
        end else begin
            step_model();
        end
    end

endmodule

//--- sim/warp_ctl_properties.sv
`timescale 1ns/10ps

module warp_ctl_properties
    import gpu_config_pkg::*;
    import warp_ctl_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_valid,
    input  logic [NW_BITS-1:0]     issue_warp,
    input  logic [NUM_THREADS-1:0] issue_mask,
    input  logic [NUM_WARPS-1:0]   active
);

    // An issued warp always has live threads
    mask_live: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> issue_mask != '0)
        else $error("issue with an empty thread mask");

    warp_live: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> active[issue_warp])
        else $error("issue from an inactive warp");

    quiet_in_reset: assert property (@(posedge clk) reset |-> !issue_valid)
        else $error("issue_valid high during reset");

endmodule

bind warp_sched warp_ctl_properties props (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_warp  (issue_warp),
    .issue_mask  (issue_mask),
    .active      (active)
);

//--- sim/warp_ctl_tb.sv
`timescale 1ns/10ps

module warp_ctl_tb
    import gpu_config_pkg::*;
    import warp_ctl_pkg::*;
();

    // Cycle budget of each test
    localparam int T_RESET     = 40;
    localparam int T_SPAWN     = 120;
    localparam int T_BRANCH    = 80;
    localparam int T_BARRIER   = 80;
    localparam int T_SPLIT     = 80;
    localparam int T_RANDOM    = 2000;
    localparam int CYCLE_LIMIT = T_RESET + T_SPAWN + T_BRANCH + T_BARRIER + T_SPLIT
                               + T_RANDOM + 100;
    localparam int WAIT_LIMIT  = 30;

    logic                   clk;
    logic                   reset;
    logic                   stall;
    logic                   ctl_valid;
    ctl_op_e                ctl_op;
    logic [NW_BITS-1:0]     ctl_warp;
    ctl_word_u              ctl_word;
    logic [31:0]            ctl_pc;
    logic                   dont_split;
    logic                   branch_valid;
    logic                   branch_taken;
    logic [31:0]            branch_dest;
    logic [NW_BITS-1:0]     branch_warp;
    logic                   wstall;
    logic [NW_BITS-1:0]     wstall_warp;
    logic                   issue_valid;
    logic [NW_BITS-1:0]     issue_warp;
    logic [31:0]            issue_pc;
    logic [NUM_THREADS-1:0] issue_mask;
    logic                   busy;

    int checks;
    int errors;
    int tb_errors   = 0;
    int cycles      = 0;
    int last_checks = 0;
    int last_errors = 0;

    tb_clkgen clkgen (
        .clk   (clk),
        .reset (reset)
    );

    warp_ctl_top uut (.*);

    warp_ctl_checker chk (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic ctl_word_u split_word(input logic [NUM_THREADS-1:0] new_m,
                                             input logic [NUM_THREADS-1:0] later_m);
        ctl_word_u w;
        w.split.new_mask   = new_m;
        w.split.later_mask = later_m;
        return w;
    endfunction

    function automatic ctl_word_u bar_word(input logic [BAR_BITS-1:0] id,
                                           input logic [NW_BITS:0] count);
        ctl_word_u w;
        w.bar.pad       = '0;
        w.bar.bar_id    = id;
        w.bar.bar_count = count;
        return w;
    endfunction

    task automatic send_ctl(input ctl_op_e op, input logic [NW_BITS-1:0] warp,
                            input ctl_word_u word, input logic [31:0] pc, input logic ds);
        @(posedge clk);
        ctl_valid  <= 1'b1;
        ctl_op     <= op;
        ctl_warp   <= warp;
        ctl_word   <= word;
        ctl_pc     <= pc;
        dont_split <= ds;
        @(posedge clk);
        ctl_valid  <= 1'b0;
    endtask

    task automatic send_branch(input logic [NW_BITS-1:0] warp, input logic taken,
                               input logic [31:0] dest);
        @(posedge clk);
        branch_valid <= 1'b1;
        branch_taken <= taken;
        branch_dest  <= dest;
        branch_warp  <= warp;
        @(posedge clk);
        branch_valid <= 1'b0;
    endtask

    task automatic hold_warp(input logic [NW_BITS-1:0] warp);
        @(posedge clk);
        wstall      <= 1'b1;
        wstall_warp <= warp;
        @(posedge clk);
        wstall      <= 1'b0;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_issue(input logic [NW_BITS-1:0] warp);
        int n;
        n = 0;
        @(negedge clk);
        while (!(issue_valid && issue_warp == warp) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!(issue_valid && issue_warp == warp)) begin
            tb_errors++;
            $display("Error at %0t: warp %0d did not issue within %0d cycles",
                     $time, warp, WAIT_LIMIT);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            tb_errors++;
            $display("Error at %0t: busy stayed high after every warp halted", $time);
        end
    endtask

    task automatic random_mix(input int n);
        repeat (n) begin
            @(posedge clk);
            stall        <= ($urandom_range(7, 0) == 0);
            ctl_valid    <= ($urandom_range(5, 0) == 0);
            ctl_op       <= ctl_op_e'(3'($urandom_range(5, 0)));
            ctl_warp     <= NW_BITS'($urandom_range(NUM_WARPS - 1, 0));
            ctl_word     <= ctl_word_u'(8'($urandom));
            ctl_pc       <= $urandom & 32'hffff_fffc;
            dont_split   <= ($urandom_range(3, 0) == 0);
            branch_valid <= ($urandom_range(5, 0) == 0);
            branch_taken <= 1'($urandom);
            branch_dest  <= $urandom & 32'hffff_fffc;
            branch_warp  <= NW_BITS'($urandom_range(NUM_WARPS - 1, 0));
            wstall       <= ($urandom_range(7, 0) == 0);
            wstall_warp  <= NW_BITS'($urandom_range(NUM_WARPS - 1, 0));
        end
        @(posedge clk);
        stall        <= 1'b0;
        ctl_valid    <= 1'b0;
        branch_valid <= 1'b0;
        wstall       <= 1'b0;
    endtask

    // Counters settle on the falling edge, so read them on the rising one
    task automatic end_test(input string name);
        int total;
        @(posedge clk);
        total = errors + tb_errors;
        $display("Test %s: %0d checks, %0d errors", name, checks - last_checks,
                 total - last_errors);
        last_checks = checks;
        last_errors = total;
    endtask

    initial begin
        void'($urandom(32'h566a));
        stall        = 1'b0;
        ctl_valid    = 1'b0;
        ctl_op       = OP_TMC;
        ctl_warp     = '0;
        ctl_word     = '0;
        ctl_pc       = '0;
        dont_split   = 1'b0;
        branch_valid = 1'b0;
        branch_taken = 1'b0;
        branch_dest  = '0;
        branch_warp  = '0;
        wstall       = 1'b0;
        wstall_warp  = '0;
        @(negedge reset);

        // Warp 0 from the startup address, then a stalled pipeline
        wait_issue(NW_BITS'(0));
        run_cycles(5);
        stall <= 1'b1;
        run_cycles(4);
        stall <= 1'b0;
        run_cycles(5);
        end_test("reset and stall");

        send_ctl(OP_WSPAWN, NW_BITS'(0), split_word('0, 4'b1110), 32'h0000_1000, 1'b0);
        wait_issue(NW_BITS'(1));
        wait_issue(NW_BITS'(2));
        wait_issue(NW_BITS'(3));
        run_cycles(8);
        for (int w = NUM_WARPS - 1; w >= 0; w--) begin
            send_ctl(OP_HALT, NW_BITS'(w), '0, '0, 1'b0);
        end
        wait_idle();
        send_ctl(OP_WSPAWN, NW_BITS'(0), split_word('0, 4'b1111), 32'h0000_2000, 1'b0);
        wait_issue(NW_BITS'(0));
        wait_issue(NW_BITS'(1));
        end_test("spawn and halt");

        hold_warp(NW_BITS'(1));
        run_cycles(6);
        send_branch(NW_BITS'(1), 1'b1, 32'h0000_3000);
        wait_issue(NW_BITS'(1));
        hold_warp(NW_BITS'(2));
        run_cycles(6);
        send_branch(NW_BITS'(2), 1'b0, '0);
        wait_issue(NW_BITS'(2));
        end_test("stall and branch");

        // Three arrivals hold, the fourth releases everyone
        for (int w = 0; w < NUM_WARPS - 1; w++) begin
            send_ctl(OP_BAR, NW_BITS'(w), bar_word(2'd1, 3'(NUM_WARPS)), '0, 1'b0);
        end
        run_cycles(6);
        send_ctl(OP_BAR, NW_BITS'(3), bar_word(2'd1, 3'(NUM_WARPS)), '0, 1'b0);
        wait_issue(NW_BITS'(0));
        wait_issue(NW_BITS'(1));
        end_test("barrier");

        send_ctl(OP_TMC, NW_BITS'(0), split_word('0, 4'b1111), '0, 1'b0);
        send_ctl(OP_SPLIT, NW_BITS'(0), split_word(4'b0011, 4'b1100), 32'h0000_4000, 1'b0);
        wait_issue(NW_BITS'(0));
        send_ctl(OP_JOIN, NW_BITS'(0), '0, '0, 1'b0);
        wait_issue(NW_BITS'(0));
        send_ctl(OP_JOIN, NW_BITS'(0), '0, '0, 1'b0);
        wait_issue(NW_BITS'(0));
        send_ctl(OP_SPLIT, NW_BITS'(0), split_word(4'b0001, 4'b1110), 32'h0000_5000, 1'b1);
        send_ctl(OP_JOIN, NW_BITS'(0), '0, '0, 1'b0);
        wait_issue(NW_BITS'(0));
        end_test("split and join");

        random_mix(T_RANDOM);
        end_test("random mix");

        $display("Totals: %0d checks, %0d errors", checks, errors + tb_errors);
        if (errors + tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/gpu_config_pkg.sv
hw/warp_ctl_pkg.sv
hw/ipdom_stack.sv
hw/barrier_table.sv
hw/warp_sched.sv
hw/warp_ctl_top.sv
sim/tb_clkgen.sv
sim/warp_ctl_properties.sv
sim/warp_ctl_checker.sv
sim/warp_ctl_tb.sv
